// ==== sources.f ====
logic/wmat_cfg_pkg.sv
logic/wmat_ctrl_pkg.sv
logic/w_row_voter.sv
logic/w_buffer.sv
logic/wb_cmd_slave.sv
logic/mac_column.sv
logic/wmat_top.sv
verif/wmat_tb.sv

// ==== Bender.yml ====
package:
  name: wmat

sources:
  - logic/wmat_cfg_pkg.sv
  - logic/wmat_ctrl_pkg.sv
  - logic/w_row_voter.sv
  - logic/w_buffer.sv
  - logic/wb_cmd_slave.sv
  - logic/mac_column.sv
  - logic/wmat_top.sv
  - target: test
    files:
      - verif/wmat_tb.sv

// ==== verif/wmat_tb.sv ====
module wmat_tb
  import wmat_cfg_pkg::*;
();

  localparam int N_XFER = 160;  // Upper bound on bus transfers in all tests

  logic          clk_i;
  logic          rst_i;
  logic          wb_cyc_i;
  logic          wb_stb_i;
  logic          wb_we_i;
  logic [AW-1:0] wb_adr_i;
  logic [DW-1:0] wb_dat_i;
  logic [DW-1:0] wb_dat_o;
  logic          wb_ack_o;

  byte             ref_tile [D][H];  // Indexed by column then row
  int              ref_acc_q [H];
  int              ref_row;
  logic [CNTW-1:0] ref_rows;
  logic [CNTW-1:0] ref_cols;
  int              seed;
  logic            ack_seen;         // Ack level at the previous falling edge

  wmat_top UUT (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "value check failed");
    end
  endtask

  function automatic logic [AW-1:0] reg_adr(input logic [2:0] word, input int lane);
    return {2'(lane), word, 2'b00};  // Lane bits only matter for ACC reads
  endfunction

  // One classic cycle entered and left 1 unit after a rising edge
  task automatic bus_xfer(input logic we, input logic [AW-1:0] adr,
                          input logic [DW-1:0] wdata, output logic [DW-1:0] rdata);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    @(posedge clk_i);
    #1;
    while (!wb_ack_o) begin
      @(posedge clk_i);
      #1;
    end
    rdata = wb_dat_o;  // Registered together with ack
    @(posedge clk_i);  // Hold the request through the ack edge
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [AW-1:0] adr, input logic [DW-1:0] data);
    logic [DW-1:0] unused;
    bus_xfer(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [AW-1:0] adr, output logic [DW-1:0] data);
    bus_xfer(1'b0, adr, '0, data);
  endtask

  // Reference model of the tile, counter and lanes
  function automatic void model_shift();
    for (int d = 0; d < D - 1; d++) begin
      for (int h = 0; h < H; h++) begin
        ref_tile[d][h] = ref_tile[d + 1][h];
      end
    end
    for (int h = 0; h < H; h++) begin
      ref_tile[D - 1][h] = 0;  // Back column refills with zeros
    end
  endfunction

  function automatic void model_load(input logic [DW-1:0] word);
    int depth;
    int lim;
    depth = (ref_cols == 0) ? D : ref_cols;
    lim   = (ref_rows == 0) ? H : ref_rows;
    model_shift();  // Row lands after the shift
    for (int d = 0; d < D; d++) begin
      if (d < depth && ref_row < lim) begin
        ref_tile[d][ref_row] = word[d*BITW +: BITW];
      end else begin
        ref_tile[d][ref_row] = 0;
      end
    end
    ref_row = (ref_row + 1) % H;
  endfunction

  function automatic void model_mac(input byte x);
    for (int h = 0; h < H; h++) begin
      ref_acc_q[h] = ref_acc_q[h] + ref_tile[0][h] * x;  // Pre-shift column with 32 bit wrap
    end
    model_shift();
  endfunction

  function automatic void model_clear();
    foreach (ref_tile[d, h]) begin
      ref_tile[d][h] = 0;
    end
    foreach (ref_acc_q[h]) begin
      ref_acc_q[h] = 0;
    end
    ref_row  = 0;
    ref_rows = '0;
    ref_cols = '0;
  endfunction

  function automatic logic [ACCW-1:0] ref_acc(input int lane);
    return ref_acc_q[lane];
  endfunction

  // Bus command plus model update
  task automatic do_cfg(input logic [DW-1:0] data);
    wb_write(reg_adr(ADDR_CFG, 0), data);
    ref_rows = data[CNTW-1:0];
    ref_cols = data[COLS_LSB +: CNTW];
  endtask

  task automatic do_load(input logic [DW-1:0] data);
    wb_write(reg_adr(ADDR_WROW, 0), data);
    model_load(data);
  endtask

  task automatic do_shift();
    wb_write(reg_adr(ADDR_SHIFT, 0), $random(seed));  // Data is ignored
    model_shift();
  endtask

  task automatic do_mac(input logic [DW-1:0] data);
    wb_write(reg_adr(ADDR_XIN, 0), data);
    model_mac(data[BITW-1:0]);
  endtask

  task automatic do_clear();
    wb_write(reg_adr(ADDR_CLEAR, 0), '0);
    model_clear();
  endtask

  task automatic check_status(input string name);
    logic [DW-1:0] v;
    wb_read(reg_adr(ADDR_STATUS, 0), v);
    check_eq(name, 32'(ref_row), v);  // Fault bit expected low
  endtask

  task automatic check_accs(input string name);
    logic [DW-1:0] v;
    for (int h = 0; h < H; h++) begin
      wb_read(reg_adr(ADDR_ACC, h), v);
      check_eq(name, ref_acc(h), v);
    end
  endtask

  task automatic run_random(input int n);
    int op;
    logic [DW-1:0] data;
    for (int i = 0; i < n; i++) begin
      op   = {$random(seed)} % 4;
      data = $random(seed);
      case (op)
        0:       do_cfg(data);
        1:       do_load(data);
        2:       do_shift();
        default: do_mac(data);
      endcase
    end
  endtask

  // Ack must drop after a single cycle
  always @(negedge clk_i) begin
    if (!rst_i && wb_ack_o && ack_seen) begin
      $display("ack stayed high for more than one cycle");
      $display("Finished with errors");
      $fatal(1, "bus protocol violation");
    end
    ack_seen <= wb_ack_o;
  end

  initial begin : watchdog
    repeat (200 * N_XFER) @(posedge clk_i);
    $display("timeout, the tests did not finish in time");
    $display("Finished with errors");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    clk_i    = 1'b0;
    rst_i    = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    ack_seen = 1'b0;
    seed     = 47465;
    model_clear();
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    check_status("reset status");
    check_accs("reset acc");

    // Full tile where every load shifts earlier rows forward
    for (int i = 0; i < 4; i++) do_load($random(seed));
    for (int i = 0; i < 4; i++) do_mac($random(seed));
    check_accs("full tile");

    // Partial tile of 3 rows by 2 columns
    do_clear();
    do_cfg(32'h0000_0023);
    for (int i = 0; i < 4; i++) do_load($random(seed));
    for (int i = 0; i < 4; i++) do_mac($random(seed));
    check_accs("leftovers");

    do_clear();
    for (int i = 0; i < 5; i++) do_load($random(seed));
    check_status("row wrap");  // Five loads leave the counter at 1
    do_shift();
    do_shift();
    for (int i = 0; i < 2; i++) do_mac($random(seed));
    check_accs("explicit shift");

    do_cfg(32'h0000_0023);
    do_clear();
    check_status("clear status");
    check_accs("clear acc");
    do_load(32'h0403_0201);  // Columns 2 and 3 only count once leftovers are gone
    for (int i = 0; i < D; i++) do_mac(32'h0000_0001);
    check_accs("clear lftovr");
    run_random(40);
    check_status("random status");
    check_accs("random acc");

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== logic/wmat_top.sv ====
module wmat_top
  import wmat_cfg_pkg::*;
  import wmat_ctrl_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          wb_cyc_i,
  input  logic          wb_stb_i,
  input  logic          wb_we_i,
  input  logic [AW-1:0] wb_adr_i,
  input  logic [DW-1:0] wb_dat_i,
  output logic [DW-1:0] wb_dat_o,
  output logic          wb_ack_o
);

  wmat_cmd_e              cmd;          // Shared command pulse
  logic [DW-1:0]          wdata;
  logic [CNTW-1:0]        rows_lftovr;
  logic [CNTW-1:0]        cols_lftovr;
  logic [CNTW-1:0]        row_cnt;
  logic                   fault;
  logic [H-1:0][BITW-1:0] w_col;
  logic [H-1:0][ACCW-1:0] acc;

  wb_cmd_slave u_slave (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .cmd_o         (cmd),
    .wdata_o       (wdata),
    .rows_lftovr_o (rows_lftovr),
    .cols_lftovr_o (cols_lftovr),
    .row_cnt_i     (row_cnt),
    .fault_i       (fault),
    .acc_i         (acc)
  );

  w_buffer u_buffer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_i         (cmd),
    .wdata_i       (wdata),
    .rows_lftovr_i (rows_lftovr),
    .cols_lftovr_i (cols_lftovr),
    .w_col_o       (w_col),
    .row_cnt_o     (row_cnt),
    .fault_o       (fault)
  );

  // Activation rides in the low byte of the XIN write
  mac_column u_mac (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .cmd_i   (cmd),
    .x_i     (wdata[BITW-1:0]),
    .w_col_i (w_col),
    .acc_o   (acc)
  );

endmodule

// ==== logic/mac_column.sv ====
module mac_column
  import wmat_cfg_pkg::*;
  import wmat_ctrl_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  wmat_cmd_e              cmd_i,
  input  logic [BITW-1:0]        x_i,      // Signed activation
  input  logic [H-1:0][BITW-1:0] w_col_i,  // Front column, pre-shift
  output logic [H-1:0][ACCW-1:0] acc_o
);

  logic [H-1:0][2*BITW-1:0] prod;      // Signed lane products
  logic [H-1:0][ACCW-1:0]   prod_ext;  // Sign extended to accumulator width
  logic [H-1:0][ACCW-1:0]   acc_q;

  always_comb begin : products
    for (int h = 0; h < H; h++) begin
      prod[h]     = $signed(w_col_i[h]) * $signed(x_i);
      prod_ext[h] = {{(ACCW - 2 * BITW){prod[h][2*BITW-1]}}, prod[h]};
    end
  end

  // Accumulate with wraparound
  always_ff @(posedge clk_i) begin
    if (rst_i || cmd_i == CMD_CLEAR) begin
      acc_q <= '0;
    end else if (cmd_i == CMD_MAC) begin
      for (int h = 0; h < H; h++) begin
        acc_q[h] <= acc_q[h] + prod_ext[h];
      end
    end
  end

  assign acc_o = acc_q;

endmodule

// ==== logic/wb_cmd_slave.sv ====
module wb_cmd_slave
  import wmat_cfg_pkg::*;
  import wmat_ctrl_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  logic [AW-1:0]          wb_adr_i,
  input  logic [DW-1:0]          wb_dat_i,
  output logic [DW-1:0]          wb_dat_o,
  output logic                   wb_ack_o,
  output wmat_cmd_e              cmd_o,          // One cycle pulse, high with ack
  output logic [DW-1:0]          wdata_o,
  output logic [CNTW-1:0]        rows_lftovr_o,
  output logic [CNTW-1:0]        cols_lftovr_o,
  input  logic [CNTW-1:0]        row_cnt_i,
  input  logic                   fault_i,
  input  logic [H-1:0][ACCW-1:0] acc_i
);

  wb_state_e       state_q;
  wb_state_e       state_d;
  logic            req;      // New transfer accepted this cycle
  logic [2:0]      reg_adr;  // Word address
  logic [SELW-1:0] acc_sel;  // Lane for accumulator reads
  wmat_cmd_e       cmd_d;
  logic [DW-1:0]   rdata_d;

  assign req     = (state_q == WB_IDLE) && wb_cyc_i && wb_stb_i;
  assign reg_adr = wb_adr_i[4:2];
  assign acc_sel = wb_adr_i[SEL_LSB +: SELW];

  // Two state ack machine, one transfer every two cycles
  always_comb begin : next_state
    state_d = state_q;
    case (state_q)
      WB_IDLE: begin
        if (req) begin
          state_d = WB_ACK;
        end
      end
      WB_ACK:  state_d = WB_IDLE;  // Ack lasts one cycle
      default: state_d = WB_IDLE;
    endcase
  end

  assign wb_ack_o = (state_q == WB_ACK);

  // Writes become commands, reads give CMD_NONE
  always_comb begin : decode
    cmd_d = CMD_NONE;
    if (req && wb_we_i) begin
      case (reg_adr)
        ADDR_CFG:   cmd_d = CMD_CFG;
        ADDR_WROW:  cmd_d = CMD_LOAD;
        ADDR_SHIFT: cmd_d = CMD_SHIFT;
        ADDR_CLEAR: cmd_d = CMD_CLEAR;
        ADDR_XIN:   cmd_d = CMD_MAC;
        default:    cmd_d = CMD_NONE;  // Writes to read only words are dropped
      endcase
    end
  end

  // Readback mux, unknown words read zero
  always_comb begin : read_mux
    rdata_d = '0;
    if (!wb_we_i) begin
      case (reg_adr)
        ADDR_STATUS: begin
          rdata_d[CNTW-1:0]  = row_cnt_i;
          rdata_d[FAULT_BIT] = fault_i;
        end
        ADDR_ACC: rdata_d = acc_i[acc_sel];
        default:  rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin : ctrl_regs
    if (rst_i) begin
      state_q <= WB_IDLE;
      cmd_o   <= CMD_NONE;
    end else begin
      state_q <= state_d;
      cmd_o   <= cmd_d;  // Pulses on the edge that raises ack
    end
  end

  // Bus data captured with the request
  always_ff @(posedge clk_i) begin : data_regs
    if (req) begin
      wdata_o  <= wb_dat_i;
      wb_dat_o <= rdata_d;
    end
  end

  // Leftovers follow the command pulse
  always_ff @(posedge clk_i) begin : lftovr_regs
    if (rst_i || cmd_o == CMD_CLEAR) begin
      rows_lftovr_o <= '0;
      cols_lftovr_o <= '0;
    end else if (cmd_o == CMD_CFG) begin
      rows_lftovr_o <= wdata_o[CNTW-1:0];
      cols_lftovr_o <= wdata_o[COLS_LSB +: CNTW];
    end
  end

  // Master holds its request until it sees ack
  a_ack_req : assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i));

endmodule

// ==== logic/w_buffer.sv ====
module w_buffer
  import wmat_cfg_pkg::*;
  import wmat_ctrl_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  wmat_cmd_e              cmd_i,
  input  logic [DW-1:0]          wdata_i,        // Row word, byte d goes to column d
  input  logic [CNTW-1:0]        rows_lftovr_i,
  input  logic [CNTW-1:0]        cols_lftovr_i,
  output logic [H-1:0][BITW-1:0] w_col_o,        // Front column
  output logic [CNTW-1:0]        row_cnt_o,
  output logic                   fault_o
);

  logic [REP-1:0][CNTW-1:0] row_v;    // Per replica next value
  logic [REP-1:0][CNTW-1:0] row_q;
  logic [CNTW-1:0]          row_d;    // Voted next value
  logic                     clear;
  logic                     load;
  logic                     shift;

  assign clear = (cmd_i == CMD_CLEAR);
  assign load  = (cmd_i == CMD_LOAD);
  assign shift = load || (cmd_i == CMD_SHIFT) || (cmd_i == CMD_MAC);  // Load implies shift

  // Each replica computes its own next value from its own state
  for (genvar r = 0; r < REP; r++) begin : gen_row_next
    always_comb begin
      if (clear) begin
        row_v[r] = '0;
      end else if (load) begin
        row_v[r] = (row_q[r] == CNTW'(H - 1)) ? '0 : row_q[r] + 1'b1;  // Wrap modulo H
      end else begin
        row_v[r] = row_q[r];
      end
    end
  end

  w_row_voter u_voter (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .clear_i (clear),
    .cnt_v_i (row_v),
    .cnt_o   (row_d),
    .fault_o (fault_o)
  );

  // Every replica takes the voted value back
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      row_q <= '0;
    end else begin
      for (int r = 0; r < REP; r++) begin
        row_q[r] <= row_d;
      end
    end
  end

  assign row_cnt_o = row_q[0];

  // Usable bounds, zero means full tile
  logic [CNTW-1:0] depth;
  logic [CNTW-1:0] row_lim;

  assign depth   = (cols_lftovr_i == '0) ? CNTW'(D) : cols_lftovr_i;
  assign row_lim = (rows_lftovr_i == '0) ? CNTW'(H) : rows_lftovr_i;

  logic [D-1:0][H-1:0][BITW-1:0] tile_d;
  logic [D-1:0][H-1:0][BITW-1:0] tile_q;

  always_comb begin : tile_next
    tile_d = tile_q;
    if (clear) begin
      tile_d = '0;
    end else if (shift) begin
      for (int d = 0; d < D - 1; d++) begin
        tile_d[d] = tile_q[d + 1];  // Move toward column 0
      end
      tile_d[D - 1] = '0;
      if (load) begin
        // Overwrite the current row after the shift
        for (int d = 0; d < D; d++) begin
          for (int h = 0; h < H; h++) begin
            if (row_q[0] == CNTW'(h)) begin
              if (CNTW'(d) < depth && row_q[0] < row_lim) begin
                tile_d[d][h] = wdata_i[d*BITW +: BITW];
              end else begin
                tile_d[d][h] = '0;  // Outside the partial tile
              end
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tile_q <= '0;
    end else begin
      tile_q <= tile_d;
    end
  end

  assign w_col_o = tile_q[0];

  // Voted feedback keeps the counter inside the tile
  a_row_range : assert property (@(posedge clk_i) disable iff (rst_i)
    row_cnt_o < CNTW'(H));

endmodule

// ==== logic/w_row_voter.sv ====
module w_row_voter
  import wmat_cfg_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     clear_i,
  input  logic [REP-1:0][CNTW-1:0] cnt_v_i,  // Replica next values
  output logic [CNTW-1:0]          cnt_o,    // Voted next value
  output logic                     fault_o
);

  logic fault_q;
  logic mismatch;  // Some replica disagrees with the vote

  // Bitwise majority
  always_comb begin : vote
    int unsigned ones;
    for (int b = 0; b < CNTW; b++) begin
      ones = 0;
      for (int r = 0; r < REP; r++) begin
        ones += cnt_v_i[r][b];
      end
      cnt_o[b] = (ones > REP / 2);
    end
  end

  always_comb begin : compare
    mismatch = 1'b0;
    for (int r = 0; r < REP; r++) begin
      if (cnt_v_i[r] != cnt_o) begin
        mismatch = 1'b1;
      end
    end
  end

  // Sticky until reset or clear
  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      fault_q <= 1'b0;
    end else if (mismatch) begin
      fault_q <= 1'b1;
    end
  end

  assign fault_o = fault_q;

endmodule

// ==== logic/wmat_ctrl_pkg.sv ====
package wmat_ctrl_pkg;

  // Command pulse from the bus slave, one cycle wide
  typedef enum logic [2:0] {
    CMD_NONE  = 3'd0,  // Idle or a read
    CMD_CFG   = 3'd1,  // Latch leftovers
    CMD_LOAD  = 3'd2,  // Shift, then write one row
    CMD_SHIFT = 3'd3,  // Plain column shift
    CMD_CLEAR = 3'd4,  // Zero tile, counters, accumulators
    CMD_MAC   = 3'd5   // Accumulate front column times x, then shift
  } wmat_cmd_e;

  // Slave handshake state
  typedef enum logic {
    WB_IDLE = 1'b0,  // Waiting for cyc and stb
    WB_ACK  = 1'b1   // Ack cycle
  } wb_state_e;

endpackage

// ==== logic/wmat_cfg_pkg.sv ====
package wmat_cfg_pkg;

  // Tile geometry
  localparam int unsigned BITW = 8;         // One weight or activation element
  localparam int unsigned H    = 4;         // Buffer rows, one MAC lane each
  localparam int unsigned D    = 4;         // Buffer depth in columns
  localparam int unsigned DW   = D * BITW;  // One loaded row word, also the bus width
  localparam int unsigned REP  = 3;         // Row counter replicas
  localparam int unsigned ACCW = 32;        // Accumulator width
  localparam int unsigned CNTW = 3;         // Row counter and leftover fields

  // Wishbone addressing
  localparam int unsigned AW      = 7;          // Byte address width
  localparam int unsigned SEL_LSB = 5;          // Lane select lives in adr[6:5]
  localparam int unsigned SELW    = $clog2(H);

  // Word addresses decoded from adr[4:2]
  localparam logic [2:0] ADDR_CFG    = 3'd0;  // W, leftovers
  localparam logic [2:0] ADDR_WROW   = 3'd1;  // W, one weight row
  localparam logic [2:0] ADDR_SHIFT  = 3'd2;  // W, data ignored
  localparam logic [2:0] ADDR_CLEAR  = 3'd3;  // W, data ignored
  localparam logic [2:0] ADDR_XIN    = 3'd4;  // W, activation in [7:0]
  localparam logic [2:0] ADDR_STATUS = 3'd5;  // R
  localparam logic [2:0] ADDR_ACC    = 3'd6;  // R, lane from adr[6:5]

  // Register field positions
  localparam int unsigned COLS_LSB  = 4;  // cols_lftovr in CFG[6:4]
  localparam int unsigned FAULT_BIT = 8;  // Sticky fault in STATUS

endpackage
